//--- rtl/quad_root_pkg.sv
`default_nettype none

package quad_root_pkg;

    // input format, b and c
    localparam int din_width = 16;
    localparam int din_point = 14;

    // discriminant format
    localparam int disc_width = 32;
    localparam int disc_point = 26;

    // table address format, sign bit included
    localparam int sqrt_in_width = 10;
    localparam int sqrt_in_point = 7;
    localparam int sqrt_addr_width = sqrt_in_width - 1;
    localparam int sqrt_depth = 2 ** sqrt_addr_width;

    // output format, roots and table entries
    localparam int dout_width = 16;
    localparam int dout_point = 13;

    // register stages from input to output
    localparam int pipe_depth = 5;

    // scaling of the table index before the integer root
    localparam int sqrt_shift = 2 * dout_point - sqrt_in_point;

    typedef struct packed {
        logic signed [din_width-1:0] b;
        logic signed [din_width-1:0] c;
    } root_in_t;

    typedef struct packed {
        logic signed [disc_width-1:0] disc;
        logic signed [din_width-1:0]  b;
    } disc_t;

    typedef struct packed {
        logic signed [sqrt_in_width-1:0] sqrt_in;
        logic signed [dout_width-1:0]    b;
    } sqrt_stage_t;

    typedef struct packed {
        logic signed [dout_width-1:0] x1;
        logic signed [dout_width-1:0] x2;
        logic                         error;
    } root_out_t;

    typedef enum logic [1:0] {
        pipe_empty,
        pipe_filling,
        pipe_streaming
    } pipe_state_e;

    // floor(sqrt(idx * 2^sqrt_shift)), i.e. point 7 in, point 13 out
    function automatic logic [dout_width-1:0] isqrt_fixed(input int unsigned idx);
        int unsigned rem;
        int unsigned res;
        int unsigned bit_v;
        rem = idx << sqrt_shift;
        res = 0;
        bit_v = 32'h4000_0000;
        for (int i = 0; i < 16; i++) begin
            if (rem >= res + bit_v) begin
                rem = rem - (res + bit_v);
                res = (res >> 1) + bit_v;
            end else begin
                res = res >> 1;
            end
            bit_v = bit_v >> 2;
        end
        return dout_width'(res);
    endfunction

endpackage

`default_nettype wire

//--- rtl/root_pipeline_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module root_pipeline_ctrl
    import quad_root_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic in_valid,
    input  wire logic out_ready,
    output logic      in_ready,
    output logic      out_valid,
    output logic      advance
);

    logic [pipe_depth-1:0] stage_valid;
    logic [pipe_depth-1:0] valid_next;
    pipe_state_e           state;
    pipe_state_e           state_next;

    // whole pipeline moves when the last slot frees up
    assign advance   = (state != pipe_streaming) || out_ready;
    assign in_ready  = advance;
    assign out_valid = stage_valid[pipe_depth-1];

    always_comb begin
        valid_next = stage_valid;
        if (advance) begin
            valid_next = {stage_valid[pipe_depth-2:0], in_valid};
        end
    end

    // occupancy follows the valid bits of the next cycle
    always_comb begin
        if (valid_next == '0) begin
            state_next = pipe_empty;
        end else if (valid_next[pipe_depth-1]) begin
            state_next = pipe_streaming;
        end else begin
            state_next = pipe_filling;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
            state       <= pipe_empty;
        end else begin
            stage_valid <= valid_next;
            state       <= state_next;
        end
    end

    // a stalled result must stay presented
    a_out_valid_held: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid
    ) else $error("out_valid dropped while out_ready was low");

    // state agrees with the stage bits
    a_state_not_empty: assert property (
        @(posedge clk) disable iff (reset)
        (|stage_valid) |-> (state != pipe_empty)
    ) else $error("state is empty while a stage holds data");

endmodule

`default_nettype wire

//--- rtl/discriminant_unit.sv
`timescale 1ns/1ps
`default_nettype none

module discriminant_unit
    import quad_root_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     advance,
    input  wire root_in_t in_data,
    output disc_t         disc
);

    // stage one: b squared at point 28
    logic signed [disc_width-1:0] b_sq;
    // c shifted so that at point 26 it reads as 4c
    logic signed [disc_width-1:0] c_scaled;
    logic signed [din_width-1:0]  b_d1;

    // stage two input after realignment
    logic signed [disc_width-1:0] b_sq_aligned;

    always_ff @(posedge clk) begin
        if (advance) begin
            b_sq     <= in_data.b * in_data.b;
            c_scaled <= disc_width'(in_data.c) <<< din_point;
            b_d1     <= in_data.b;
        end
    end

    // point 28 down to point 26
    assign b_sq_aligned = b_sq >>> (2 * din_point - disc_point);

    // inputs stay below 2 in magnitude, wrap not reachable in practice
    always_ff @(posedge clk) begin
        if (advance) begin
            disc.disc <= b_sq_aligned - c_scaled;
            disc.b    <= b_d1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fixed_cast.sv
`timescale 1ns/1ps
`default_nettype none

module fixed_cast #(
    parameter int in_width  = 32,
    parameter int in_point  = 26,
    parameter int out_width = 10,
    parameter int out_point = 7
) (
    input  wire logic                  clk,
    input  wire logic                  advance,
    input  wire logic signed [in_width-1:0] din,
    output logic signed [out_width-1:0]     dout
);

    localparam int shift_r = (in_point > out_point) ? in_point - out_point : 0;
    localparam int shift_l = (out_point > in_point) ? out_point - in_point : 0;
    localparam int ext_width = (in_width + shift_l > out_width) ? in_width + shift_l
                                                                : out_width;

    // limits of the output range, held in the wide format
    localparam logic signed [ext_width-1:0] out_max =
        {{(ext_width - out_width + 1){1'b0}}, {(out_width - 1){1'b1}}};
    localparam logic signed [ext_width-1:0] out_min = ~out_max;

    logic signed [ext_width-1:0] aligned;

    // arithmetic shift right truncates toward minus infinity
    assign aligned = (ext_width'(din) <<< shift_l) >>> shift_r;

    always_ff @(posedge clk) begin
        if (advance) begin
            if (aligned > out_max) begin
                dout <= out_max[out_width-1:0];
            end else if (aligned < out_min) begin
                dout <= out_min[out_width-1:0];
            end else begin
                dout <= aligned[out_width-1:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/sqrt_rom.sv
`timescale 1ns/1ps
`default_nettype none

module sqrt_rom
    import quad_root_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                advance,
    input  wire sqrt_stage_t         sqrt_in,
    output logic signed [dout_width-1:0] root,
    output logic signed [dout_width-1:0] b_out,
    output logic                     error
);

    logic signed [dout_width-1:0] rom_table [sqrt_depth];
    logic [sqrt_addr_width-1:0]   addr;
    logic                         negative;

    // table contents are constants of the index
    for (genvar i = 0; i < sqrt_depth; i++) begin : g_rom
        assign rom_table[i] = isqrt_fixed(i);
    end

    assign addr     = sqrt_in.sqrt_in[sqrt_addr_width-1:0];
    assign negative = sqrt_in.sqrt_in[sqrt_in_width-1];

    always_ff @(posedge clk) begin
        if (advance) begin
            // negative discriminant reads the zero entry
            if (negative) begin
                root <= rom_table[0];
            end else begin
                root <= rom_table[addr];
            end
            b_out <= sqrt_in.b;
            error <= negative;
        end
    end

    // a valid root is never negative
    a_root_nonneg: assert property (
        @(posedge clk)
        !error |-> (root >= 0)
    ) else $error("negative root without the error flag");

endmodule

`default_nettype wire

//--- rtl/root_combiner.sv
`timescale 1ns/1ps
`default_nettype none

module root_combiner
    import quad_root_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     advance,
    input  wire logic signed [dout_width-1:0] root,
    input  wire logic signed [dout_width-1:0] b,
    input  wire logic                     error,
    output root_out_t                     out_data
);

    // one extra bit so that -b plus root cannot wrap
    logic signed [dout_width:0] neg_b;
    logic signed [dout_width:0] sum;
    logic signed [dout_width:0] diff;
    logic signed [dout_width:0] sum_half;
    logic signed [dout_width:0] diff_half;

    assign neg_b = -((dout_width + 1)'(b));
    assign sum   = neg_b + (dout_width + 1)'(root);
    assign diff  = neg_b - (dout_width + 1)'(root);

    // divide by two, truncated
    assign sum_half  = sum >>> 1;
    assign diff_half = diff >>> 1;

    always_ff @(posedge clk) begin
        if (advance) begin
            out_data.x1    <= sum_half[dout_width-1:0];
            out_data.x2    <= diff_half[dout_width-1:0];
            // roots are meaningless when this is set
            out_data.error <= error;
        end
    end

endmodule

`default_nettype wire

//--- rtl/quad_root_top.sv
`timescale 1ns/1ps
`default_nettype none

module quad_root_top
    import quad_root_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      in_valid,
    output logic           in_ready,
    input  wire root_in_t  in_data,
    output logic           out_valid,
    input  wire logic      out_ready,
    output root_out_t      out_data
);

    logic                            advance;
    disc_t                           disc;
    logic signed [sqrt_in_width-1:0] disc_q;
    logic signed [dout_width-1:0]    b_q;
    sqrt_stage_t                     sqrt_stage;
    logic signed [dout_width-1:0]    root;
    logic signed [dout_width-1:0]    b_d;
    logic                            error;

    root_pipeline_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .advance   (advance)
    );

    // stages 1 and 2
    discriminant_unit u_disc (
        .clk     (clk),
        .advance (advance),
        .in_data (in_data),
        .disc    (disc)
    );

    // stage 3, both casts side by side
    fixed_cast #(
        .in_width  (disc_width),
        .in_point  (disc_point),
        .out_width (sqrt_in_width),
        .out_point (sqrt_in_point)
    ) disc_cast (
        .clk     (clk),
        .advance (advance),
        .din     (disc.disc),
        .dout    (disc_q)
    );

    fixed_cast #(
        .in_width  (din_width),
        .in_point  (din_point),
        .out_width (dout_width),
        .out_point (dout_point)
    ) b_cast (
        .clk     (clk),
        .advance (advance),
        .din     (disc.b),
        .dout    (b_q)
    );

    assign sqrt_stage = '{sqrt_in: disc_q, b: b_q};

    // stage 4
    sqrt_rom u_sqrt (
        .clk     (clk),
        .advance (advance),
        .sqrt_in (sqrt_stage),
        .root    (root),
        .b_out   (b_d),
        .error   (error)
    );

    // stage 5
    root_combiner u_comb (
        .clk      (clk),
        .advance  (advance),
        .root     (root),
        .b        (b_d),
        .error    (error),
        .out_data (out_data)
    );

endmodule

`default_nettype wire

//--- bench/quad_root_tb.sv
`timescale 1ns/1ps
`default_nettype none

module quad_root_tb
    import quad_root_pkg::*;
;

    localparam int n_directed  = 7;
    localparam int n_burst     = 40;
    localparam int n_random    = 300;
    localparam int n_total     = n_directed + n_burst + n_random;
    localparam int cycle_limit = 20 * n_total + 100;

    logic      clk;
    logic      reset;
    logic      in_valid;
    logic      in_ready;
    root_in_t  in_data;
    logic      out_valid;
    logic      out_ready;
    root_out_t out_data;

    logic [15:0] lfsr_state;
    root_out_t   exp_q[$];
    int          acc_q[$];
    bit          timed_q[$];
    root_out_t   held_data;
    logic        held;
    logic        in_taken;
    int          cycle;
    int          sent;
    int          sent_limit;
    int          mismatch_count;
    int          protocol_count;
    int          checked_count;

    quad_root_top DUT (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[14:0], lfsr_state[0]};
        end
    endtask

    // real roots, negative discriminant, zero and saturated cases
    function automatic root_in_t directed_vector(input int i);
        root_in_t v;
        case (i)
            0: v = '{b: -16'sd12288, c: 16'sd2048};
            1: v = '{b: 16'sd0, c: -16'sd4096};
            2: v = '{b: 16'sd0, c: 16'sd8192};
            3: v = '{b: 16'sd8192, c: 16'sd16383};
            4: v = '{b: -16'sd32768, c: -16'sd32768};
            5: v = '{b: 16'sd32767, c: -16'sd32768};
            default: v = '{b: 16'sd0, c: 16'sd0};
        endcase
        return v;
    endfunction

    // bitwise search for floor of the square root
    function automatic longint int_sqrt(input longint n);
        longint r;
        longint t;
        r = 0;
        for (int k = 15; k >= 0; k--) begin
            t = r | (longint'(1) << k);
            if (t * t <= n) begin
                r = t;
            end
        end
        return r;
    endfunction

    function automatic root_out_t model_roots(input root_in_t v);
        root_out_t m;
        longint    b;
        longint    c;
        longint    disc;
        longint    idx;
        longint    root;
        longint    b_half;
        b = $signed(v.b);
        c = $signed(v.c);
        // b squared minus 4c at point 26
        disc = ((b * b) >>> (2 * din_point - disc_point)) - c * (longint'(1) << din_point);
        idx = disc >>> (disc_point - sqrt_in_point);
        if (idx > 511) begin
            idx = 511;
        end else if (idx < -512) begin
            idx = -512;
        end
        m.error = (idx < 0);
        root = m.error ? 0 : int_sqrt(idx << (2 * dout_point - sqrt_in_point));
        b_half = b >>> (din_point - dout_point);
        m.x1 = dout_width'((-b_half + root) >>> 1);
        m.x2 = dout_width'((-b_half - root) >>> 1);
        return m;
    endfunction

    task automatic check_roots(input root_out_t got, input root_out_t exp);
        if (got.x1 !== exp.x1) begin
            mismatch_count++;
            $display("mismatch at %0t: out_data.x1 got %0d expected %0d", $time, got.x1, exp.x1);
        end
        if (got.x2 !== exp.x2) begin
            mismatch_count++;
            $display("mismatch at %0t: out_data.x2 got %0d expected %0d", $time, got.x2, exp.x2);
        end
    endtask

    task automatic check_error(input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: out_data.error got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // drive at the falling edge, sample 1 ns later while everything is settled
    task automatic run_cycle(input logic random_flow);
        logic [15:0] r;
        root_out_t   exp;
        int          acc;
        bit          timed;
        @(negedge clk);
        if (in_valid && in_taken) begin
            in_valid = 1'b0;
        end
        if (!in_valid && sent < sent_limit) begin
            r = 16'h1;
            if (random_flow) begin
                random_bits(2, r);
            end
            if (r[1:0] != 2'b00) begin
                if (sent < n_directed) begin
                    in_data = directed_vector(sent);
                end else begin
                    random_bits(16, r);
                    in_data.b = r;
                    random_bits(16, r);
                    in_data.c = r;
                end
                sent++;
                in_valid = 1'b1;
            end
        end
        if (random_flow) begin
            random_bits(1, r);
            out_ready = r[0];
        end else begin
            out_ready = 1'b1;
        end
        #1;
        in_taken = in_valid && in_ready;
        if (in_taken) begin
            exp_q.push_back(model_roots(in_data));
            acc_q.push_back(cycle);
            timed_q.push_back(!random_flow);
        end
        // a stalled result must not move
        if (held) begin
            if (!out_valid) begin
                protocol_count++;
                $display("out_valid dropped at %0t while a result was stalled", $time);
            end else begin
                check_roots(out_data, held_data);
                check_error(out_data.error, held_data.error);
            end
        end
        held = out_valid && !out_ready;
        held_data = out_data;
        if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                protocol_count++;
                $display("unexpected output at %0t with no accepted input left", $time);
            end else begin
                exp = exp_q.pop_front();
                acc = acc_q.pop_front();
                timed = timed_q.pop_front();
                checked_count++;
                check_error(out_data.error, exp.error);
                if (!exp.error) begin
                    check_roots(out_data, exp);
                end
                if (timed && cycle - acc != pipe_depth) begin
                    protocol_count++;
                    $display("result at %0t came %0d cycles after its input, not %0d",
                             $time, cycle - acc, pipe_depth);
                end
            end
        end
    endtask

    initial begin : watchdog
        cycle = 0;
        while (cycle < cycle_limit) begin
            @(posedge clk);
            cycle = cycle + 1;
        end
        $display("timeout after %0d cycles, %0d results still expected", cycle, exp_q.size());
        $display("Test failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        out_ready = 1'b0;
        lfsr_state = 16'd63;
        held = 1'b0;
        in_taken = 1'b0;
        sent = 0;
        mismatch_count = 0;
        protocol_count = 0;
        checked_count = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);
        // burst with the output always ready
        sent_limit = n_directed + n_burst;
        while (sent < sent_limit || (in_valid && !in_taken) || exp_q.size() != 0) begin
            run_cycle(1'b0);
        end
        // random valid and back-pressure
        sent_limit = n_total;
        while (sent < sent_limit || (in_valid && !in_taken) || exp_q.size() != 0) begin
            run_cycle(1'b1);
        end
        repeat (2 * pipe_depth) run_cycle(1'b0);
        if (exp_q.size() != 0) begin
            protocol_count++;
            $display("%0d accepted inputs never produced a result", exp_q.size());
        end
        $display("%0d results checked, %0d mismatches, %0d protocol errors",
                 checked_count, mismatch_count, protocol_count);
        if (mismatch_count == 0 && protocol_count == 0 && checked_count == n_total) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
rtl/quad_root_pkg.sv
rtl/root_pipeline_ctrl.sv
rtl/discriminant_unit.sv
rtl/fixed_cast.sv
rtl/sqrt_rom.sv
rtl/root_combiner.sv
rtl/quad_root_top.sv
bench/quad_root_tb.sv

//--- Makefile
# Verilator build and run for the quadratic root pipeline

VERILATOR ?= verilator
TOP       ?= quad_root_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
